/* tiny_proc.f */
source/tiny_proc_pkg.sv
source/tiny_proc_bypass_queue.sv
source/tiny_proc_drop_unit.sv
source/tiny_proc_ctrl.sv
source/tiny_proc_dpath.sv
source/tiny_proc.sv
dv/tiny_proc_assertions.sv
dv/tiny_proc_tb.sv

/* dv/tiny_proc_tb.sv */
//------------------------------
// tiny_proc testbench
// random-stall memory, manager source, ISA reference model
//------------------------------

`timescale 1ns/1ps

module tiny_proc_tb
  import tiny_proc_pkg::*;
();

  localparam int MEM_WORDS = 1024;
  localparam int TIMEOUT   = 20000;
  localparam int NUM_IN    = 3;

  logic        clk, reset;
  logic [31:0] mngr2proc_msg, proc2mngr_msg, imem_req_addr, imem_resp_msg;
  logic        mngr2proc_val, mngr2proc_rdy, proc2mngr_val, proc2mngr_rdy;
  logic        imem_req_val, imem_req_rdy, imem_resp_val, imem_resp_rdy;
  logic        dmem_req_type, dmem_req_val, dmem_req_rdy;
  logic [31:0] dmem_req_addr, dmem_req_data, dmem_resp_msg;
  logic        dmem_resp_val, dmem_resp_rdy;

  logic [31:0] mem [MEM_WORDS];
  logic [31:0] ref_mem [MEM_WORDS];
  logic [31:0] mngr_in [NUM_IN];
  logic [31:0] exp_q [$];
  logic [31:0] lcg_state;
  int          load_idx, mngr_idx, rx_count, cycles, i;
  int          out_err, mem_err, hang_err, total_err;
  bit          ipend, dpend;

  tiny_proc dut_i (.*);

  always #4 clk = ~clk;

  //------------------------------
  // instruction builders
  //------------------------------
  function automatic logic [31:0] add_inst(input logic [4:0] rd, rs1, rs2);
    return {7'd0, rs2, rs1, 3'b000, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] addi_inst(input logic [4:0] rd, rs1, input logic [31:0] imm);
    return {imm[11:0], rs1, 3'b000, rd, OPC_OPIMM};
  endfunction

  function automatic logic [31:0] lw_inst(input logic [4:0] rd, rs1, input logic [31:0] imm);
    return {imm[11:0], rs1, 3'b010, rd, OPC_LOAD};
  endfunction

  function automatic logic [31:0] sw_inst(input logic [4:0] rs2, rs1, input logic [31:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] bne_inst(input logic [4:0] rs1, rs2, input logic [31:0] off);
    return {off[12], off[10:5], rs2, rs1, 3'b001, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] jal_inst(input logic [4:0] rd, input logic [31:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  function automatic logic [31:0] csrr_inst(input logic [4:0] rd);
    return {CSR_MNGR2PROC, 5'd0, 3'b010, rd, OPC_SYSTEM};
  endfunction

  function automatic logic [31:0] csrw_inst(input logic [4:0] rs1);
    return {CSR_PROC2MNGR, rs1, 3'b001, 5'd0, OPC_SYSTEM};
  endfunction

  // 1 in 100 granularity, upper lcg bits only
  function automatic bit chance(input int pct);
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return (int'(lcg_state[31:16]) % 100) < pct;
  endfunction

  task automatic put_inst(input logic [31:0] inst);
    mem[load_idx] = inst;
    load_idx++;
  endtask

  //------------------------------
  // program image
  //------------------------------
  task automatic load_image();
    int k;
    // fill keyed on the full word index
    for (k = 0; k < MEM_WORDS; k++)
      mem[k] = (k * 32'h9E37_79B1) ^ 32'h5A5A_0000;
    mngr_in[0] = 32'h0000_1234;
    mngr_in[1] = 32'hFFFF_FF00;
    mngr_in[2] = 32'h7000_0001;
    load_idx = int'(RESET_PC[11:2]);
    // arithmetic and back-to-back dependences
    put_inst(csrr_inst(1));
    put_inst(csrr_inst(2));
    put_inst(add_inst(3, 1, 2));
    put_inst(addi_inst(4, 3, 100));
    put_inst(addi_inst(4, 4, -7));
    put_inst(csrw_inst(3));
    put_inst(csrw_inst(4));
    // x0 stays zero
    put_inst(addi_inst(0, 1, 5));
    put_inst(csrw_inst(0));
    // stores then loads, 8(x5) is never written
    put_inst(addi_inst(5, 0, 32'h400));
    put_inst(sw_inst(1, 5, 0));
    put_inst(sw_inst(4, 5, 4));
    put_inst(sw_inst(3, 5, 12));
    put_inst(lw_inst(6, 5, 4));
    put_inst(csrw_inst(6));
    put_inst(lw_inst(7, 5, 8));
    put_inst(csrw_inst(7));
    put_inst(lw_inst(8, 5, 12));
    put_inst(add_inst(8, 8, 6));
    put_inst(csrw_inst(8));
    // three-pass loop, bne taken twice then falls through
    put_inst(addi_inst(9, 0, 3));
    put_inst(addi_inst(10, 0, 0));
    put_inst(add_inst(10, 10, 1));
    put_inst(addi_inst(9, 9, -1));
    put_inst(sw_inst(10, 5, 16));
    put_inst(bne_inst(9, 0, -12));
    put_inst(csrw_inst(10));
    // jal skips two, link goes out
    put_inst(jal_inst(11, 12));
    put_inst(csrw_inst(1));
    put_inst(addi_inst(10, 0, 99));
    put_inst(csrw_inst(11));
    put_inst(csrw_inst(10));
    put_inst(csrr_inst(12));
    put_inst(addi_inst(12, 12, 1));
    put_inst(csrw_inst(12));
    // load behind the last store drains the dmem queue
    put_inst(lw_inst(13, 5, 16));
    put_inst(csrw_inst(13));
    // spin in place
    put_inst(jal_inst(0, 0));
  endtask

  //------------------------------
  // ISA reference model
  //------------------------------
  function automatic void run_reference();
    logic [31:0] regs [32];
    logic [31:0] pc, pc_next, raw, imm, addr;
    inst_u       w;
    int          in_idx;
    int          steps;
    bit          halted;
    for (int r = 0; r < 32; r++)
      regs[r] = 32'd0;
    pc     = RESET_PC;
    in_idx = 0;
    steps  = 0;
    halted = 1'b0;
    while (!halted && steps < 5000)
    begin
      w       = ref_mem[pc[11:2]];
      raw     = w;
      pc_next = pc + 32'd4;
      steps++;
      case (w.r_fmt.opcode)
        OPC_OP:
          regs[w.r_fmt.rd] = regs[w.r_fmt.rs1] + regs[w.r_fmt.rs2];
        OPC_OPIMM:
          regs[w.i_fmt.rd] = regs[w.i_fmt.rs1] + {{20{raw[31]}}, raw[31:20]};
        OPC_LOAD:
        begin
          addr = regs[w.i_fmt.rs1] + {{20{raw[31]}}, raw[31:20]};
          regs[w.i_fmt.rd] = ref_mem[addr[11:2]];
        end
        OPC_STORE:
        begin
          addr = regs[w.s_fmt.rs1] + {{20{raw[31]}}, raw[31:25], raw[11:7]};
          ref_mem[addr[11:2]] = regs[w.s_fmt.rs2];
        end
        OPC_BRANCH:
        begin
          imm = {{19{raw[31]}}, raw[31], raw[7], raw[30:25], raw[11:8], 1'b0};
          if (regs[w.b_fmt.rs1] != regs[w.b_fmt.rs2])
            pc_next = pc + imm;
        end
        OPC_JAL:
        begin
          imm = {{11{raw[31]}}, raw[31], raw[19:12], raw[20], raw[30:21], 1'b0};
          // jump to self ends the program
          if (imm == 32'd0)
            halted = 1'b1;
          regs[w.r_fmt.rd] = pc + 32'd4;
          pc_next = pc + imm;
        end
        OPC_SYSTEM:
        begin
          if (w.i_fmt.imm12 == CSR_MNGR2PROC)
          begin
            regs[w.i_fmt.rd] = mngr_in[in_idx];
            in_idx++;
          end
          else if (w.i_fmt.imm12 == CSR_PROC2MNGR)
            exp_q.push_back(regs[w.i_fmt.rs1]);
        end
        default: halted = 1'b1;
      endcase
      regs[0] = 32'd0;
      pc = pc_next;
    end
  endfunction

  //------------------------------
  // checks
  //------------------------------
  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
    begin
      $display("error: %s expected %h actual %h", name, exp, act);
      out_err++;
    end
  endtask

  task automatic check_mem(input string name, input logic [31:0] addr,
                           input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
    begin
      $display("error: %s at %h expected %h actual %h", name, addr, exp, act);
      mem_err++;
    end
  endtask

  // every proc2mngr transfer against the reference sequence
  always @(negedge clk)
  begin
    if (!reset && proc2mngr_val && proc2mngr_rdy)
    begin
      if (rx_count < exp_q.size())
        check_word($sformatf("proc2mngr #%0d", rx_count), exp_q[rx_count], proc2mngr_msg);
      else
      begin
        $display("error: unexpected extra proc2mngr output %h", proc2mngr_msg);
        out_err++;
      end
      rx_count++;
    end
  end

  //------------------------------
  // memory and manager models
  //------------------------------
  always
  begin : stream_models
    logic        in_reset, ireq_fire, iresp_fire, dreq_fire, dresp_fire, m2p_fire;
    logic        dreq_type_s;
    logic [31:0] ireq_addr_s, dreq_addr_s, dreq_data_s;
    // handshakes sampled mid-cycle
    @(negedge clk);
    in_reset    = reset;
    ireq_fire   = !in_reset && imem_req_val && imem_req_rdy;
    iresp_fire  = !in_reset && imem_resp_val && imem_resp_rdy;
    dreq_fire   = !in_reset && dmem_req_val && dmem_req_rdy;
    dresp_fire  = !in_reset && dmem_resp_val && dmem_resp_rdy;
    m2p_fire    = !in_reset && mngr2proc_val && mngr2proc_rdy;
    ireq_addr_s = imem_req_addr;
    dreq_type_s = dmem_req_type;
    dreq_addr_s = dmem_req_addr;
    dreq_data_s = dmem_req_data;
    @(posedge clk);
    #1;
    if (in_reset)
    begin
      {imem_req_rdy, imem_resp_val, dmem_req_rdy, dmem_resp_val} = '0;
      {mngr2proc_val, proc2mngr_rdy, ipend, dpend} = '0;
    end
    else
    begin
      // imem answers a cycle after the request at the earliest
      if (iresp_fire)
      begin
        imem_resp_val = 1'b0;
        ipend = 1'b0;
      end
      if (ireq_fire)
      begin
        ipend = 1'b1;
        imem_resp_msg = mem[ireq_addr_s[11:2]];
      end
      if (ipend && !imem_resp_val)
        imem_resp_val = chance(70);
      imem_req_rdy = !ipend && chance(70);
      // stores complete on request, loads get a response
      if (dresp_fire)
      begin
        dmem_resp_val = 1'b0;
        dpend = 1'b0;
      end
      if (dreq_fire)
      begin
        if (dreq_type_s == MEM_REQ_WRITE)
          mem[dreq_addr_s[11:2]] = dreq_data_s;
        else
        begin
          dpend = 1'b1;
          dmem_resp_msg = mem[dreq_addr_s[11:2]];
        end
      end
      if (dpend && !dmem_resp_val)
        dmem_resp_val = chance(60);
      dmem_req_rdy = !dpend && chance(60);
      // manager source with random gaps
      if (m2p_fire)
      begin
        mngr2proc_val = 1'b0;
        mngr_idx++;
      end
      if (!mngr2proc_val && mngr_idx < NUM_IN && chance(40))
      begin
        mngr2proc_val = 1'b1;
        mngr2proc_msg = mngr_in[mngr_idx];
      end
      proc2mngr_rdy = chance(60);
    end
  end

  //------------------------------
  // main sequence
  //------------------------------
  initial
  begin
    clk = 1'b0;
    reset = 1'b1;
    {mngr2proc_msg, imem_resp_msg, dmem_resp_msg} = '0;
    {mngr2proc_val, proc2mngr_rdy, imem_req_rdy, imem_resp_val} = '0;
    {dmem_req_rdy, dmem_resp_val, ipend, dpend} = '0;
    {mngr_idx, rx_count, out_err, mem_err, hang_err} = '0;
    lcg_state = 32'd87287;
    load_image();
    ref_mem = mem;
    run_reference();

    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    cycles = 0;
    while (rx_count < exp_q.size() && cycles < TIMEOUT)
    begin
      @(negedge clk);
      cycles++;
    end
    if (rx_count < exp_q.size())
    begin
      $display("timeout: only %0d of %0d proc2mngr outputs arrived", rx_count, exp_q.size());
      hang_err++;
    end
    else
    begin
      // let any queued store reach memory
      cycles = 0;
      while ((dmem_req_val || dpend) && cycles < 1000)
      begin
        @(negedge clk);
        cycles++;
      end
      if (dmem_req_val || dpend)
      begin
        $display("timeout: dmem traffic never went idle after the last output");
        hang_err++;
      end
      // watch for stray outputs
      repeat (20) @(negedge clk);
    end

    for (i = 0; i < MEM_WORDS; i++)
      check_mem("final memory", i * 4, ref_mem[i], mem[i]);

    total_err = out_err + mem_err + hang_err + dut_i.assertions_i.fail_cnt;
    $display("errors: %0d output, %0d memory, %0d hang, %0d assertion (%0d outputs)",
             out_err, mem_err, hang_err, dut_i.assertions_i.fail_cnt, rx_count);
    if (total_err == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* dv/tiny_proc_assertions.sv */
//------------------------------
// tiny_proc stream assertions
// request hold under back-pressure, quiet ports after reset
//------------------------------

`timescale 1ns/1ps

module tiny_proc_assertions
(
  input logic        clk,
  input logic        reset,
  input logic        imem_req_val,
  input logic        imem_req_rdy,
  input logic [31:0] imem_req_addr,
  input logic        dmem_req_val,
  input logic        dmem_req_rdy,
  input logic        dmem_req_type,
  input logic [31:0] dmem_req_addr,
  input logic [31:0] dmem_req_data,
  input logic        proc2mngr_val,
  input logic        proc2mngr_rdy,
  input logic [31:0] proc2mngr_msg,
  input logic        mngr2proc_rdy,
  input logic        dmem_resp_rdy
);

  // read back by the testbench
  int fail_cnt = 0;

  // a stalled source keeps val and msg until the transfer
  imem_req_hold: assert property (@(posedge clk) disable iff (reset)
    imem_req_val && !imem_req_rdy |=> imem_req_val && $stable(imem_req_addr))
  else
  begin
    fail_cnt++;
    $error("imem request dropped or changed while stalled");
  end

  dmem_req_hold: assert property (@(posedge clk) disable iff (reset)
    dmem_req_val && !dmem_req_rdy |=> dmem_req_val &&
      $stable({dmem_req_type, dmem_req_addr, dmem_req_data}))
  else
  begin
    fail_cnt++;
    $error("dmem request dropped or changed while stalled");
  end

  proc2mngr_hold: assert property (@(posedge clk) disable iff (reset)
    proc2mngr_val && !proc2mngr_rdy |=> proc2mngr_val && $stable(proc2mngr_msg))
  else
  begin
    fail_cnt++;
    $error("proc2mngr message dropped or changed while stalled");
  end

  // first cycle out of reset, only fetch is active
  reset_quiet: assert property (@(posedge clk)
    $fell(reset) |-> imem_req_val && !dmem_req_val && !proc2mngr_val &&
      !mngr2proc_rdy && !dmem_resp_rdy)
  else
  begin
    fail_cnt++;
    $error("stream handshakes not idle in the first cycle after reset");
  end

endmodule

bind tiny_proc tiny_proc_assertions assertions_i
(
  .clk           (clk),
  .reset         (reset),
  .imem_req_val  (imem_req_val),
  .imem_req_rdy  (imem_req_rdy),
  .imem_req_addr (imem_req_addr),
  .dmem_req_val  (dmem_req_val),
  .dmem_req_rdy  (dmem_req_rdy),
  .dmem_req_type (dmem_req_type),
  .dmem_req_addr (dmem_req_addr),
  .dmem_req_data (dmem_req_data),
  .proc2mngr_val (proc2mngr_val),
  .proc2mngr_rdy (proc2mngr_rdy),
  .proc2mngr_msg (proc2mngr_msg),
  .mngr2proc_rdy (mngr2proc_rdy),
  .dmem_resp_rdy (dmem_resp_rdy)
);

/* source/tiny_proc.sv */
//------------------------------
// tiny_proc top
// 3-stage core with streaming mem and manager ports
//------------------------------

`timescale 1ns/1ps

module tiny_proc
  import tiny_proc_pkg::*;
(
  input  logic        clk,
  input  logic        reset,

  input  logic [31:0] mngr2proc_msg,
  input  logic        mngr2proc_val,
  output logic        mngr2proc_rdy,

  output logic [31:0] proc2mngr_msg,
  output logic        proc2mngr_val,
  input  logic        proc2mngr_rdy,

  output logic [31:0] imem_req_addr,
  output logic        imem_req_val,
  input  logic        imem_req_rdy,

  input  logic [31:0] imem_resp_msg,
  input  logic        imem_resp_val,
  output logic        imem_resp_rdy,

  output logic        dmem_req_type,
  output logic [31:0] dmem_req_addr,
  output logic [31:0] dmem_req_data,
  output logic        dmem_req_val,
  input  logic        dmem_req_rdy,

  input  logic [31:0] dmem_resp_msg,
  input  logic        dmem_resp_val,
  output logic        dmem_resp_rdy
);

  // queue enq side
  logic [31:0] ireq_addr_enq, dreq_addr_enq, dreq_data_enq, p2m_msg_enq;
  logic        ireq_val_enq, ireq_rdy_enq, dreq_val_enq, dreq_rdy_enq;
  logic        dreq_type_enq, p2m_val_enq, p2m_rdy_enq;

  // drop unit output side
  logic [31:0] iresp_msg_d;
  logic        iresp_val_d, iresp_rdy_d, drop;

  // ctrl to dpath
  logic        reg_en_f, reg_en_d, reg_en_x, pc_sel_f, rf_wen_x, br_taken_d;
  logic [1:0]  imm_type_d, op2_sel_d, alu_fn_x, wb_sel_x;
  logic [4:0]  rf_waddr_x;
  inst_u       inst_d;

  //------------------------------
  // request and manager queues
  //------------------------------
  tiny_proc_bypass_queue #(.MSG_BITS(32)) imem_req_q_i
  (
    .clk     (clk),
    .reset   (reset),
    .enq_msg (ireq_addr_enq),
    .enq_val (ireq_val_enq),
    .enq_rdy (ireq_rdy_enq),
    .deq_msg (imem_req_addr),
    .deq_val (imem_req_val),
    .deq_rdy (imem_req_rdy)
  );

  tiny_proc_bypass_queue #(.MSG_BITS(MEM_REQ_BITS)) dmem_req_q_i
  (
    .clk     (clk),
    .reset   (reset),
    .enq_msg ({dreq_type_enq, dreq_addr_enq, dreq_data_enq}),
    .enq_val (dreq_val_enq),
    .enq_rdy (dreq_rdy_enq),
    .deq_msg ({dmem_req_type, dmem_req_addr, dmem_req_data}),
    .deq_val (dmem_req_val),
    .deq_rdy (dmem_req_rdy)
  );

  tiny_proc_bypass_queue #(.MSG_BITS(32)) proc2mngr_q_i
  (
    .clk     (clk),
    .reset   (reset),
    .enq_msg (p2m_msg_enq),
    .enq_val (p2m_val_enq),
    .enq_rdy (p2m_rdy_enq),
    .deq_msg (proc2mngr_msg),
    .deq_val (proc2mngr_val),
    .deq_rdy (proc2mngr_rdy)
  );

  tiny_proc_drop_unit drop_unit_i
  (
    .clk         (clk),
    .reset       (reset),
    .drop        (drop),
    .istream_msg (imem_resp_msg),
    .istream_val (imem_resp_val),
    .istream_rdy (imem_resp_rdy),
    .ostream_msg (iresp_msg_d),
    .ostream_val (iresp_val_d),
    .ostream_rdy (iresp_rdy_d)
  );

  //------------------------------
  // control and datapath
  //------------------------------
  tiny_proc_ctrl ctrl_i
  (
    .clk           (clk),
    .reset         (reset),
    .imem_req_val  (ireq_val_enq),
    .imem_req_rdy  (ireq_rdy_enq),
    .imem_resp_val (iresp_val_d),
    .imem_resp_rdy (iresp_rdy_d),
    .drop          (drop),
    .dmem_req_val  (dreq_val_enq),
    .dmem_req_rdy  (dreq_rdy_enq),
    .dmem_req_type (dreq_type_enq),
    .dmem_resp_val (dmem_resp_val),
    .dmem_resp_rdy (dmem_resp_rdy),
    .mngr2proc_val (mngr2proc_val),
    .mngr2proc_rdy (mngr2proc_rdy),
    .proc2mngr_val (p2m_val_enq),
    .proc2mngr_rdy (p2m_rdy_enq),
    .reg_en_f      (reg_en_f),
    .reg_en_d      (reg_en_d),
    .reg_en_x      (reg_en_x),
    .pc_sel_f      (pc_sel_f),
    .imm_type_d    (imm_type_d),
    .op2_sel_d     (op2_sel_d),
    .alu_fn_x      (alu_fn_x),
    .wb_sel_x      (wb_sel_x),
    .rf_wen_x      (rf_wen_x),
    .rf_waddr_x    (rf_waddr_x),
    .inst_d        (inst_d),
    .br_taken_d    (br_taken_d)
  );

  tiny_proc_dpath dpath_i
  (
    .clk            (clk),
    .reset          (reset),
    .reg_en_f       (reg_en_f),
    .reg_en_d       (reg_en_d),
    .reg_en_x       (reg_en_x),
    .pc_sel_f       (pc_sel_f),
    .imm_type_d     (imm_type_d),
    .op2_sel_d      (op2_sel_d),
    .alu_fn_x       (alu_fn_x),
    .wb_sel_x       (wb_sel_x),
    .rf_wen_x       (rf_wen_x),
    .rf_waddr_x     (rf_waddr_x),
    .imem_req_addr  (ireq_addr_enq),
    .imem_resp_msg  (iresp_msg_d),
    .dmem_req_addr  (dreq_addr_enq),
    .dmem_req_data  (dreq_data_enq),
    .dmem_resp_data (dmem_resp_msg),
    .mngr2proc_msg  (mngr2proc_msg),
    .proc2mngr_msg  (p2m_msg_enq),
    .inst_d         (inst_d),
    .br_taken_d     (br_taken_d)
  );

endmodule

/* source/tiny_proc_dpath.sv */
//------------------------------
// tiny_proc datapath
// pc, regfile, immediates, alu and writeback
//------------------------------

`timescale 1ns/1ps

module tiny_proc_dpath
  import tiny_proc_pkg::*;
(
  input  logic        clk,
  input  logic        reset,

  input  logic        reg_en_f,
  input  logic        reg_en_d,
  input  logic        reg_en_x,
  input  logic        pc_sel_f,
  input  logic [1:0]  imm_type_d,
  input  logic [1:0]  op2_sel_d,
  input  logic [1:0]  alu_fn_x,
  input  logic [1:0]  wb_sel_x,
  input  logic        rf_wen_x,
  input  logic [4:0]  rf_waddr_x,

  output logic [31:0] imem_req_addr,
  input  logic [31:0] imem_resp_msg,
  output logic [31:0] dmem_req_addr,
  output logic [31:0] dmem_req_data,
  input  logic [31:0] dmem_resp_data,
  input  logic [31:0] mngr2proc_msg,
  output logic [31:0] proc2mngr_msg,

  output inst_u       inst_d,
  output logic        br_taken_d
);

  logic [31:0] pc_f, pc_d, br_target_d;
  logic [31:0] rf [32];
  logic [31:0] rs1_data, rs2_data, imm_d, op2_d;
  logic [31:0] op1_x, op2_x, sdata_x, alu_out_x, wb_data_x;

  //------------------------------
  // F and D registers
  //------------------------------
  // pc_f stays on the outstanding fetch until its response lands
  always_ff @(posedge clk)
  begin
    if (reset)
      pc_f <= RESET_PC;
    else if (reg_en_f)
      pc_f <= pc_sel_f ? br_target_d : pc_f + 32'd4;
  end

  always_ff @(posedge clk)
  begin
    if (reg_en_d)
    begin
      pc_d   <= pc_f;
      inst_d <= imem_resp_msg;
    end
  end

  assign imem_req_addr = pc_f;

  // x0 hardwired to zero on read
  assign rs1_data = (inst_d.r_fmt.rs1 == 5'd0) ? 32'd0 : rf[inst_d.r_fmt.rs1];
  assign rs2_data = (inst_d.r_fmt.rs2 == 5'd0) ? 32'd0 : rf[inst_d.r_fmt.rs2];

  // sign-extended immediates
  always_comb
  begin
    case (imm_type_d)
      IMM_S:   imm_d = {{20{inst_d.s_fmt.imm_hi[6]}}, inst_d.s_fmt.imm_hi,
                        inst_d.s_fmt.imm_lo};
      IMM_B:   imm_d = {{20{inst_d.b_fmt.imm12}}, inst_d.b_fmt.imm11,
                        inst_d.b_fmt.imm10_5, inst_d.b_fmt.imm4_1, 1'b0};
      // j bits sit where the i view has rs1, funct3 and imm12
      IMM_J:   imm_d = {{12{inst_d.i_fmt.imm12[11]}}, inst_d.i_fmt.rs1,
                        inst_d.i_fmt.funct3, inst_d.i_fmt.imm12[0],
                        inst_d.i_fmt.imm12[10:1], 1'b0};
      default: imm_d = {{20{inst_d.i_fmt.imm12[11]}}, inst_d.i_fmt.imm12};
    endcase
  end

  always_comb
  begin
    case (op2_sel_d)
      OP2_RF:  op2_d = rs2_data;
      OP2_PC4: op2_d = pc_d + 32'd4;
      default: op2_d = imm_d;
    endcase
  end

  // bne compare and shared target adder
  assign br_taken_d  = (rs1_data != rs2_data);
  assign br_target_d = pc_d + imm_d;

  //------------------------------
  // X stage
  //------------------------------
  always_ff @(posedge clk)
  begin
    if (reg_en_x)
    begin
      op1_x   <= rs1_data;
      op2_x   <= op2_d;
      sdata_x <= rs2_data;
    end
  end

  assign alu_out_x = (alu_fn_x == ALU_CP_OP2) ? op2_x : op1_x + op2_x;

  always_comb
  begin
    case (wb_sel_x)
      WB_MEM:  wb_data_x = dmem_resp_data;
      WB_MNGR: wb_data_x = mngr2proc_msg;
      default: wb_data_x = alu_out_x;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rf_wen_x)
      rf[rf_waddr_x] <= wb_data_x;
  end

  assign dmem_req_addr = alu_out_x;
  assign dmem_req_data = sdata_x;
  // csrw sends rs1 as read in D
  assign proc2mngr_msg = op1_x;

endmodule

/* source/tiny_proc_ctrl.sv */
//------------------------------
// tiny_proc control unit
// stage valids, decode, stalls, redirect and handshakes
//------------------------------

`timescale 1ns/1ps

module tiny_proc_ctrl
  import tiny_proc_pkg::*;
(
  input  logic       clk,
  input  logic       reset,

  output logic       imem_req_val,
  input  logic       imem_req_rdy,
  input  logic       imem_resp_val,
  output logic       imem_resp_rdy,
  output logic       drop,

  output logic       dmem_req_val,
  input  logic       dmem_req_rdy,
  output logic       dmem_req_type,
  input  logic       dmem_resp_val,
  output logic       dmem_resp_rdy,

  input  logic       mngr2proc_val,
  output logic       mngr2proc_rdy,
  output logic       proc2mngr_val,
  input  logic       proc2mngr_rdy,

  output logic       reg_en_f,
  output logic       reg_en_d,
  output logic       reg_en_x,
  output logic       pc_sel_f,
  output logic [1:0] imm_type_d,
  output logic [1:0] op2_sel_d,
  output logic [1:0] alu_fn_x,
  output logic [1:0] wb_sel_x,
  output logic       rf_wen_x,
  output logic [4:0] rf_waddr_x,

  input  inst_u      inst_d,
  input  logic       br_taken_d
);

  logic       pend_f, val_d, val_x;
  logic       lw_x, sw_x, csrr_x, csrw_x, wen_x, req_done_x;
  logic       req_fire, resp_fire, dreq_fire;
  logic       done_x, stall_x, raw_d, stall_d, go_d, redirect;
  logic       rs1_en, rs2_en, wen_d, lw_d, sw_d, csrr_d, csrw_d, bne_d, jal_d;
  logic [1:0] alu_fn_d, wb_sel_d;

  //------------------------------
  // D decode
  //------------------------------
  always_comb
  begin
    {rs1_en, rs2_en, wen_d, lw_d, sw_d, csrr_d, csrw_d, bne_d, jal_d} = '0;
    imm_type_d = IMM_I;
    op2_sel_d  = OP2_IMM;
    alu_fn_d   = ALU_ADD;
    wb_sel_d   = WB_ALU;
    case (inst_d.r_fmt.opcode)
      OPC_OP:
      begin
        {rs1_en, rs2_en, wen_d} = 3'b111;
        op2_sel_d = OP2_RF;
      end
      // addi, lw and sw share the i/s immediate path
      OPC_OPIMM:  {rs1_en, wen_d} = 2'b11;
      OPC_LOAD:
      begin
        {rs1_en, wen_d, lw_d} = 3'b111;
        wb_sel_d = WB_MEM;
      end
      OPC_STORE:
      begin
        {rs1_en, rs2_en, sw_d} = 3'b111;
        imm_type_d = IMM_S;
      end
      OPC_BRANCH:
      begin
        {rs1_en, rs2_en, bne_d} = 3'b111;
        imm_type_d = IMM_B;
      end
      OPC_JAL:
      begin
        {wen_d, jal_d} = 2'b11;
        imm_type_d = IMM_J;
        op2_sel_d  = OP2_PC4;
        alu_fn_d   = ALU_CP_OP2;
      end
      OPC_SYSTEM:
      begin
        // csr number selects the direction
        csrr_d   = (inst_d.i_fmt.imm12 == CSR_MNGR2PROC);
        csrw_d   = (inst_d.i_fmt.imm12 == CSR_PROC2MNGR);
        wen_d    = csrr_d;
        rs1_en   = csrw_d;
        alu_fn_d = ALU_CP_OP2;
        wb_sel_d = WB_MNGR;
      end
      default: ;
    endcase
  end

  //------------------------------
  // X completion and handshakes
  //------------------------------
  assign dmem_req_val  = val_x && (lw_x || sw_x) && !req_done_x;
  assign dmem_req_type = sw_x ? MEM_REQ_WRITE : MEM_REQ_READ;
  assign dmem_resp_rdy = val_x && lw_x && req_done_x;
  assign mngr2proc_rdy = val_x && csrr_x;
  assign proc2mngr_val = val_x && csrw_x;
  assign dreq_fire     = dmem_req_val && dmem_req_rdy;

  always_comb
  begin
    if (lw_x)        done_x = dmem_resp_val && dmem_resp_rdy;
    else if (sw_x)   done_x = dreq_fire;
    else if (csrr_x) done_x = mngr2proc_val;
    else if (csrw_x) done_x = proc2mngr_rdy;
    else             done_x = 1'b1;
  end

  assign stall_x  = val_x && !done_x;
  assign rf_wen_x = val_x && wen_x && done_x;

  // no forwarding, so wait for the writer in X to retire
  assign raw_d = val_x && wen_x && (rf_waddr_x != 5'd0) &&
                 ((rs1_en && rf_waddr_x == inst_d.r_fmt.rs1) ||
                  (rs2_en && rf_waddr_x == inst_d.r_fmt.rs2));
  assign stall_d  = stall_x || raw_d;
  assign go_d     = val_d && !stall_d;
  assign reg_en_x = go_d;

  //------------------------------
  // fetch and redirect
  //------------------------------
  assign imem_req_val  = !pend_f;
  assign req_fire      = imem_req_val && imem_req_rdy;
  assign imem_resp_rdy = !val_d || go_d;
  assign resp_fire     = imem_resp_val && imem_resp_rdy;

  assign redirect = go_d && (jal_d || (bne_d && br_taken_d));
  // squash the one fetch issued past the branch
  assign drop     = redirect && (pend_f || req_fire);
  assign pc_sel_f = redirect;
  assign reg_en_f = resp_fire || redirect;
  assign reg_en_d = resp_fire;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      {pend_f, val_d, val_x, req_done_x} <= '0;
      {lw_x, sw_x, csrr_x, csrw_x, wen_x} <= '0;
      alu_fn_x   <= ALU_ADD;
      wb_sel_x   <= WB_ALU;
      rf_waddr_x <= 5'd0;
    end
    else
    begin
      if (redirect)       pend_f <= 1'b0;
      else if (req_fire)  pend_f <= 1'b1;
      else if (resp_fire) pend_f <= 1'b0;

      if (resp_fire)      val_d <= 1'b1;
      else if (go_d)      val_d <= 1'b0;

      if (go_d)
      begin
        val_x      <= 1'b1;
        req_done_x <= 1'b0;
        {lw_x, sw_x, csrr_x, csrw_x, wen_x} <= {lw_d, sw_d, csrr_d, csrw_d, wen_d};
        alu_fn_x   <= alu_fn_d;
        wb_sel_x   <= wb_sel_d;
        rf_waddr_x <= inst_d.r_fmt.rd;
      end
      else
      begin
        if (done_x)    val_x      <= 1'b0;
        if (dreq_fire) req_done_x <= 1'b1;
      end
    end
  end

endmodule

/* source/tiny_proc_drop_unit.sv */
//------------------------------
// imem response drop unit
// swallows the wrong-path response after a redirect
//------------------------------

`timescale 1ns/1ps

module tiny_proc_drop_unit
(
  input  logic        clk,
  input  logic        reset,

  input  logic        drop,

  input  logic [31:0] istream_msg,
  input  logic        istream_val,
  output logic        istream_rdy,

  output logic [31:0] ostream_msg,
  output logic        ostream_val,
  input  logic        ostream_rdy
);

  logic drop_pend_q;
  logic drop_active;

  // drop applies to the very next response, even in the same cycle
  assign drop_active = drop || drop_pend_q;

  assign ostream_msg = istream_msg;
  assign ostream_val = istream_val && !drop_active;

  // consumed locally while dropping
  assign istream_rdy = drop_active ? 1'b1 : ostream_rdy;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      drop_pend_q <= 1'b0;
    end
    else if (drop_active && istream_val)
    begin
      // wrong-path response gone
      drop_pend_q <= 1'b0;
    end
    else if (drop)
    begin
      drop_pend_q <= 1'b1;
    end
  end

endmodule

/* source/tiny_proc_bypass_queue.sv */
//------------------------------
// one-entry bypass queue
// passes through when empty, holds under back-pressure
//------------------------------

`timescale 1ns/1ps

module tiny_proc_bypass_queue
#(
  parameter int MSG_BITS = 32
)
(
  input  logic                clk,
  input  logic                reset,

  input  logic [MSG_BITS-1:0] enq_msg,
  input  logic                enq_val,
  output logic                enq_rdy,

  output logic [MSG_BITS-1:0] deq_msg,
  output logic                deq_val,
  input  logic                deq_rdy
);

  logic                full_q;
  logic [MSG_BITS-1:0] entry_q;
  logic                capture;

  // entry free means enq always accepted
  assign enq_rdy = !full_q;

  // stored entry has priority over the bypass path
  assign deq_val = full_q || enq_val;
  assign deq_msg = full_q ? entry_q : enq_msg;

  // enq seen but downstream not taking it
  assign capture = !full_q && enq_val && !deq_rdy;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      full_q <= 1'b0;
    end
    else if (full_q && deq_rdy)
    begin
      full_q <= 1'b0;
    end
    else if (capture)
    begin
      full_q <= 1'b1;
    end
  end

  // payload only, qualified by full_q
  always_ff @(posedge clk)
  begin
    if (capture)
    begin
      entry_q <= enq_msg;
    end
  end

endmodule

/* source/tiny_proc_pkg.sv */
//------------------------------
// tiny_proc shared definitions
// opcodes, select codes, instruction views
//------------------------------

package tiny_proc_pkg;

  // major opcodes of the subset
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // manager csr numbers
  localparam logic [11:0] CSR_MNGR2PROC = 12'hFC0;
  localparam logic [11:0] CSR_PROC2MNGR = 12'h7C0;

  // alu function
  localparam logic [1:0] ALU_ADD    = 2'd0;
  localparam logic [1:0] ALU_CP_OP2 = 2'd1;

  // writeback source
  localparam logic [1:0] WB_ALU  = 2'd0;
  localparam logic [1:0] WB_MEM  = 2'd1;
  localparam logic [1:0] WB_MNGR = 2'd2;

  // immediate format
  localparam logic [1:0] IMM_I = 2'd0;
  localparam logic [1:0] IMM_S = 2'd1;
  localparam logic [1:0] IMM_B = 2'd2;
  localparam logic [1:0] IMM_J = 2'd3;

  // operand 2 source in D
  localparam logic [1:0] OP2_RF  = 2'd0;
  localparam logic [1:0] OP2_IMM = 2'd1;
  localparam logic [1:0] OP2_PC4 = 2'd2;

  // dmem request layout is {type, addr, data}
  localparam logic MEM_REQ_READ  = 1'b0;
  localparam logic MEM_REQ_WRITE = 1'b1;
  localparam int   MEM_REQ_BITS  = 65;

  localparam logic [31:0] RESET_PC = 32'h200;

  // one instruction word, four field layouts
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_fmt;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s_fmt;
    struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
    } b_fmt;
  } inst_u;

endpackage
